// ==== logic/laser_bus_pkg.sv ====
package laser_bus_pkg;

	// One Z80 bus cycle as the board sees it
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
	} cpu_bus_t;

	// Byte written to 6800, kept raw and read back as fields
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [1:0] unused_hi;
			logic       speaker_b;
			logic       css;         // Colour set select
			logic       ag;          // Alpha/graphics mode
			logic       cass_out;
			logic       unused_lo;
			logic       speaker_a;
		} f;
	} io_latch_u;

	typedef struct packed {
		logic [1:0] speaker;         // Bit 1 is latch bit 5
		logic       cass_out;
		logic       ag;
		logic       css;
	} io_outputs_t;

	localparam logic [15:0] IO_BASE   = 16'h6800;
	localparam logic [15:0] IO_SIZE   = 16'h0800;
	localparam logic [15:0] VRAM_BASE = 16'h7000;
	localparam logic [15:0] VRAM_SIZE = 16'h0800;
	localparam logic [15:0] RAM_BASE  = 16'h7800;
	localparam logic [15:0] RAM_SIZE  = 16'h4000;

	localparam int VRAM_AW = 11;
	localparam int RAM_AW  = 14;

	// Last phase of a CPU clock period
	localparam logic [3:0] PHASE_LAST_NORMAL = 4'd13;
	localparam logic [3:0] PHASE_LAST_TURBO  = 4'd3;

endpackage

// ==== logic/laser_kbd_pkg.sv ====
package laser_kbd_pkg;

	typedef struct packed {
		logic [7:0] code;            // PS/2 set 2 scan code
		logic       extended;        // E0 prefix seen
		logic       pressed;
	} kbd_event_t;

	typedef logic [63:0] key_matrix_t;   // Row r, column k at r*8+k, low = pressed
	typedef logic [9:0]  key_extra_t;    // Keys outside the matrix, low = pressed

	// Scan codes handled outside the plain matrix table
	localparam logic [7:0] SC_CTRL   = 8'h14;
	localparam logic [7:0] SC_LSHIFT = 8'h12;
	localparam logic [7:0] SC_RSHIFT = 8'h59;
	localparam logic [7:0] SC_ALT    = 8'h11;
	localparam logic [7:0] SC_ESC    = 8'h76;
	localparam logic [7:0] SC_UP     = 8'h75;
	localparam logic [7:0] SC_LEFT   = 8'h6B;
	localparam logic [7:0] SC_RIGHT  = 8'h74;
	localparam logic [7:0] SC_DOWN   = 8'h72;
	localparam logic [7:0] SC_BKSP   = 8'h66;

	// Matrix positions that take part in folding
	localparam logic [5:0] KEY_IDX_CTRL   = 6'd10;
	localparam logic [5:0] KEY_IDX_LSHIFT = 6'd18;
	localparam logic [5:0] KEY_IDX_DOT    = 6'd33;
	localparam logic [5:0] KEY_IDX_COMMA  = 6'd35;
	localparam logic [5:0] KEY_IDX_SPACE  = 6'd36;
	localparam logic [5:0] KEY_IDX_M      = 6'd37;
	localparam logic [5:0] KEY_IDX_MINUS  = 6'd42;

	// Bits of key_extra_t
	localparam int EX_RSHIFT = 0;
	localparam int EX_REPEAT = 1;
	localparam int EX_LF     = 2;
	localparam int EX_ESC    = 3;
	localparam int EX_UP     = 4;
	localparam int EX_LEFT   = 5;
	localparam int EX_RIGHT  = 6;
	localparam int EX_DOWN   = 7;
	localparam int EX_BKSP   = 8;

endpackage

// ==== logic/sync_ram.sv ====
`timescale 1ns/1ns

module sync_ram #(
	parameter int ADDR_W = 11,
	parameter int DATA_W = 8
) (
	input  logic              CLK50MHZ,
	input  logic              we_i,
	input  logic [ADDR_W-1:0] addr_a_i,
	input  logic [DATA_W-1:0] data_a_i,
	output logic [DATA_W-1:0] data_a_o,
	input  logic [ADDR_W-1:0] addr_b_i,
	output logic [DATA_W-1:0] data_b_o
);

	logic [DATA_W-1:0] mem [2**ADDR_W];

	// Read-first on port A
	always_ff @(posedge CLK50MHZ)
	begin
		if (we_i)
			mem[addr_a_i] <= data_a_i;
		data_a_o <= mem[addr_a_i];
		data_b_o <= mem[addr_b_i];   // Video side, read only
	end

endmodule

// ==== logic/cpu_phase_gen.sv ====
`timescale 1ns/1ns

module cpu_phase_gen #(
	parameter logic [3:0] NORMAL_LAST = laser_bus_pkg::PHASE_LAST_NORMAL,
	parameter logic [3:0] TURBO_LAST  = laser_bus_pkg::PHASE_LAST_TURBO
) (
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic turbo_i,
	output logic cpu_clk_o,
	output logic mem_op_o
);

	logic [3:0] phase_q;
	logic       phase_end;
	logic       strobe_q;

	// Turbo only matters at the turbo wrap point
	assign phase_end = (phase_q == NORMAL_LAST) ||
	                   ((phase_q == TURBO_LAST) && turbo_i);

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			phase_q  <= 4'd0;
			strobe_q <= 1'b0;
		end
		else
		begin
			strobe_q <= (phase_q == 4'd0);   // One cycle wide
			if (phase_end)
				phase_q <= 4'd0;
			else
				phase_q <= phase_q + 4'd1;
		end
	end

	// Memory strobe rides on the CPU clock edge
	assign cpu_clk_o = strobe_q;
	assign mem_op_o  = strobe_q;

endmodule

// ==== logic/mem_map_decoder.sv ====
`timescale 1ns/1ns

module mem_map_decoder (
	input  logic                       CLK50MHZ,
	input  logic                       RESET_N,
	input  laser_bus_pkg::cpu_bus_t    bus_i,
	input  logic                       mem_op_i,
	input  logic [7:0]                 ram_rd_i,
	input  logic [7:0]                 vram_rd_i,
	input  logic [7:0]                 kbd_rd_i,
	output logic                       ram_we_o,
	output logic                       vram_we_o,
	output logic [7:0]                 rd_data_o,
	output laser_bus_pkg::io_outputs_t io_o
);
	import laser_bus_pkg::*;

	logic       sel_io;
	logic       sel_vram;
	logic       sel_ram;
	logic       mem_wr;
	logic       rd_phase_q;
	logic [7:0] rd_mux;
	io_latch_u  latch_q;

	// Offset compare, wraps below the base
	assign sel_io   = (bus_i.addr - IO_BASE) < IO_SIZE;
	assign sel_vram = (bus_i.addr - VRAM_BASE) < VRAM_SIZE;
	assign sel_ram  = (bus_i.addr - RAM_BASE) < RAM_SIZE;

	assign mem_wr    = mem_op_i & bus_i.mreq & bus_i.wr & ~bus_i.iorq;
	assign ram_we_o  = mem_wr & sel_ram;
	assign vram_we_o = mem_wr & sel_vram;

	always_comb
	begin
		if (sel_ram)
			rd_mux = ram_rd_i;
		else if (sel_vram)
			rd_mux = vram_rd_i;
		else if (sel_io)
			rd_mux = kbd_rd_i;    // Keyboard sits under the latch
		else
			rd_mux = 8'hFF;       // Open bus
	end

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			latch_q.raw <= 8'h00;
			rd_phase_q  <= 1'b0;
			rd_data_o   <= 8'hFF;
		end
		else
		begin
			// One cycle after the strobe the RAM output is settled
			rd_phase_q <= mem_op_i;
			if (mem_wr && sel_io)
				latch_q.raw <= bus_i.wdata;
			if (rd_phase_q && bus_i.mreq && bus_i.rd)
				rd_data_o <= rd_mux;
		end
	end

	assign io_o.speaker  = {latch_q.f.speaker_b, latch_q.f.speaker_a};
	assign io_o.cass_out = latch_q.f.cass_out;
	assign io_o.ag       = latch_q.f.ag;
	assign io_o.css      = latch_q.f.css;

endmodule

// ==== logic/keyboard_matrix.sv ====
`timescale 1ns/1ns

module keyboard_matrix (
	input  logic                     CLK50MHZ,
	input  logic                     RESET_N,
	input  logic                     key_strobe_i,
	input  laser_kbd_pkg::kbd_event_t event_i,
	input  logic [7:0]               row_sel_i,
	input  logic                     cass_in_i,
	output logic [7:0]               rd_data_o
);
	import laser_kbd_pkg::*;

	key_matrix_t key_q;
	key_matrix_t key_eff;
	key_extra_t  extra_q;
	logic        map_hit;
	logic [5:0]  map_idx;
	logic        key_up;

	// Scan code to matrix position, MSB flags a hit
	function automatic logic [6:0] scan_lookup(input logic [7:0] code);
		logic [6:0] res;
		res = 7'd0;
		case (code)
			8'h2C:     res = {1'b1, 6'd0};    // T
			8'h1D:     res = {1'b1, 6'd1};    // W
			8'h24:     res = {1'b1, 6'd3};    // E
			8'h15:     res = {1'b1, 6'd4};    // Q
			8'h2D:     res = {1'b1, 6'd5};    // R
			8'h34:     res = {1'b1, 6'd8};    // G
			8'h1B:     res = {1'b1, 6'd9};    // S
			SC_CTRL:   res = {1'b1, KEY_IDX_CTRL};
			8'h23:     res = {1'b1, 6'd11};   // D
			8'h1C:     res = {1'b1, 6'd12};   // A
			8'h2B:     res = {1'b1, 6'd13};   // F
			8'h32:     res = {1'b1, 6'd16};   // B
			8'h22:     res = {1'b1, 6'd17};   // X
			SC_LSHIFT: res = {1'b1, KEY_IDX_LSHIFT};
			8'h21:     res = {1'b1, 6'd19};   // C
			8'h1A:     res = {1'b1, 6'd20};   // Z
			8'h2A:     res = {1'b1, 6'd21};   // V
			8'h2E:     res = {1'b1, 6'd24};   // 5
			8'h1E:     res = {1'b1, 6'd25};   // 2
			8'h26:     res = {1'b1, 6'd27};   // 3
			8'h16:     res = {1'b1, 6'd28};   // 1
			8'h25:     res = {1'b1, 6'd29};   // 4
			8'h31:     res = {1'b1, 6'd32};   // N
			8'h49:     res = {1'b1, KEY_IDX_DOT};
			8'h41:     res = {1'b1, KEY_IDX_COMMA};
			8'h29:     res = {1'b1, KEY_IDX_SPACE};
			8'h3A:     res = {1'b1, KEY_IDX_M};
			8'h36:     res = {1'b1, 6'd40};   // 6
			8'h46:     res = {1'b1, 6'd41};   // 9
			8'h4E:     res = {1'b1, KEY_IDX_MINUS};
			8'h3E:     res = {1'b1, 6'd43};   // 8
			8'h45:     res = {1'b1, 6'd44};   // 0
			8'h3D:     res = {1'b1, 6'd45};   // 7
			8'h35:     res = {1'b1, 6'd48};   // Y
			8'h44:     res = {1'b1, 6'd49};   // O
			8'h5A:     res = {1'b1, 6'd50};   // Return
			8'h43:     res = {1'b1, 6'd51};   // I
			8'h4D:     res = {1'b1, 6'd52};   // P
			8'h3C:     res = {1'b1, 6'd53};   // U
			8'h33:     res = {1'b1, 6'd56};   // H
			8'h4B:     res = {1'b1, 6'd57};   // L
			8'h52:     res = {1'b1, 6'd58};   // Quote as colon
			8'h42:     res = {1'b1, 6'd59};   // K
			8'h4C:     res = {1'b1, 6'd60};   // Semicolon
			8'h3B:     res = {1'b1, 6'd61};   // J
			default:   res = 7'd0;
		endcase
		return res;
	endfunction

	assign {map_hit, map_idx} = scan_lookup(event_i.code);
	assign key_up = ~event_i.pressed;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			key_q   <= '1;
			extra_q <= '1;
		end
		else if (key_strobe_i)
		begin
			if (map_hit)
				key_q[map_idx] <= key_up;
			case (event_i.code)
				SC_RSHIFT: extra_q[EX_RSHIFT] <= key_up;
				SC_ALT:
				begin
					// Left Alt is Repeat, right Alt is LF
					if (event_i.extended)
						extra_q[EX_LF] <= key_up;
					else
						extra_q[EX_REPEAT] <= key_up;
				end
				SC_ESC:    extra_q[EX_ESC] <= key_up;
				SC_UP:     extra_q[EX_UP] <= key_up;
				SC_LEFT:   extra_q[EX_LEFT] <= key_up;
				SC_RIGHT:  extra_q[EX_RIGHT] <= key_up;
				SC_DOWN:   extra_q[EX_DOWN] <= key_up;
				SC_BKSP:   extra_q[EX_BKSP] <= key_up;
				default:   ;
			endcase
		end
	end

	// Extra keys show up as Ctrl plus a matrix key
	always_comb
	begin
		key_eff = key_q;
		key_eff[KEY_IDX_MINUS]  = key_q[KEY_IDX_MINUS] & extra_q[EX_ESC];
		key_eff[KEY_IDX_DOT]    = key_q[KEY_IDX_DOT] & extra_q[EX_UP];
		key_eff[KEY_IDX_M]      = key_q[KEY_IDX_M] & extra_q[EX_LEFT] & extra_q[EX_BKSP];
		key_eff[KEY_IDX_COMMA]  = key_q[KEY_IDX_COMMA] & extra_q[EX_RIGHT];
		key_eff[KEY_IDX_SPACE]  = key_q[KEY_IDX_SPACE] & extra_q[EX_DOWN];
		key_eff[KEY_IDX_CTRL]   = key_q[KEY_IDX_CTRL] & (&extra_q[EX_BKSP:EX_ESC]);
		key_eff[KEY_IDX_LSHIFT] = key_q[KEY_IDX_LSHIFT] & extra_q[EX_RSHIFT];
	end

	// Any selected row with the key down pulls the column low
	always_comb
	begin
		rd_data_o = {1'b1, ~cass_in_i, 6'h3F};
		for (int r = 0; r < 8; r++)
			for (int k = 0; k < 6; k++)
				if (!row_sel_i[r] && !key_eff[r*8+k])
					rd_data_o[k] = 1'b0;
	end

endmodule

// ==== logic/laser310_top.sv ====
`timescale 1ns/1ns

module laser310_top #(
	parameter int         VRAM_AW     = laser_bus_pkg::VRAM_AW,
	parameter int         RAM_AW      = laser_bus_pkg::RAM_AW,
	parameter logic [3:0] NORMAL_LAST = laser_bus_pkg::PHASE_LAST_NORMAL,
	parameter logic [3:0] TURBO_LAST  = laser_bus_pkg::PHASE_LAST_TURBO
) (
	input  logic                       CLK50MHZ,
	input  logic                       RESET_N,
	input  laser_bus_pkg::cpu_bus_t    bus_i,
	input  logic                       turbo_i,
	input  logic                       key_strobe_i,
	input  logic                       key_pressed_i,
	input  logic                       key_extended_i,
	input  logic [7:0]                 key_code_i,
	input  logic                       cass_in_i,
	input  logic [VRAM_AW-1:0]         vdg_addr_i,
	output logic                       cpu_clk_o,
	output logic [7:0]                 rd_data_o,
	output laser_bus_pkg::io_outputs_t io_o,
	output logic [7:0]                 vdg_data_o
);
	import laser_kbd_pkg::*;

	logic       mem_op;
	logic       ram_we;
	logic       vram_we;
	logic [7:0] ram_rd;
	logic [7:0] vram_rd;
	logic [7:0] kbd_rd;
	kbd_event_t key_event;

	assign key_event.code     = key_code_i;
	assign key_event.extended = key_extended_i;
	assign key_event.pressed  = key_pressed_i;

	cpu_phase_gen #(
		.NORMAL_LAST(NORMAL_LAST),
		.TURBO_LAST (TURBO_LAST)
	) u_phase (
		.CLK50MHZ (CLK50MHZ),
		.RESET_N  (RESET_N),
		.turbo_i  (turbo_i),
		.cpu_clk_o(cpu_clk_o),
		.mem_op_o (mem_op)
	);

	mem_map_decoder u_decoder (
		.CLK50MHZ (CLK50MHZ),
		.RESET_N  (RESET_N),
		.bus_i    (bus_i),
		.mem_op_i (mem_op),
		.ram_rd_i (ram_rd),
		.vram_rd_i(vram_rd),
		.kbd_rd_i (kbd_rd),
		.ram_we_o (ram_we),
		.vram_we_o(vram_we),
		.rd_data_o(rd_data_o),
		.io_o     (io_o)
	);

	// Port B feeds the video generator
	sync_ram #(.ADDR_W(VRAM_AW), .DATA_W(8)) vram (
		.CLK50MHZ(CLK50MHZ),
		.we_i    (vram_we),
		.addr_a_i(bus_i.addr[VRAM_AW-1:0]),
		.data_a_i(bus_i.wdata),
		.data_a_o(vram_rd),
		.addr_b_i(vdg_addr_i),
		.data_b_o(vdg_data_o)
	);

	sync_ram #(.ADDR_W(RAM_AW), .DATA_W(8)) main_ram (
		.CLK50MHZ(CLK50MHZ),
		.we_i    (ram_we),
		.addr_a_i(bus_i.addr[RAM_AW-1:0]),   // 7800-B7FF folds onto 3800-37FF
		.data_a_i(bus_i.wdata),
		.data_a_o(ram_rd),
		.addr_b_i('0),
		.data_b_o()
	);

	keyboard_matrix u_kbd (
		.CLK50MHZ    (CLK50MHZ),
		.RESET_N     (RESET_N),
		.key_strobe_i(key_strobe_i),
		.event_i     (key_event),
		.row_sel_i   (bus_i.addr[7:0]),
		.cass_in_i   (cass_in_i),
		.rd_data_o   (kbd_rd)
	);

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial
	begin
		clk_o   = 1'b0;
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;    // Release away from the active edge
	end

	always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// ==== dv/laser310_assertions.sv ====
`timescale 1ns/1ns

module laser310_assertions (
	input logic CLK50MHZ,
	input logic RESET_N,
	input logic turbo_i,
	input logic cpu_clk_o
);

	logic [4:0] gap_q;      // Cycles since the last CPU clock pulse
	logic       seen_q;
	logic       turbo_q;    // Turbo level at the wrap decision

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			gap_q   <= 5'd0;
			seen_q  <= 1'b0;
			turbo_q <= 1'b0;
		end
		else
		begin
			if (cpu_clk_o)
			begin
				gap_q  <= 5'd1;
				seen_q <= 1'b1;
			end
			else if (gap_q != 5'd31)
				gap_q <= gap_q + 5'd1;
			if (gap_q == 5'd2)
				turbo_q <= turbo_i;   // Phase 3
		end
	end

	strobe_width: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		cpu_clk_o |=> !cpu_clk_o)
		else $error("CPU clock pulse wider than one cycle");

	pulse_spacing: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		seen_q && cpu_clk_o |-> gap_q == (turbo_q ? 5'd4 : 5'd14))
		else $error("CPU clock pulse spacing %0d cycles", gap_q);

	// A lost pulse shows up as a growing gap
	pulse_missing: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		seen_q |-> gap_q <= 5'd14)
		else $error("CPU clock pulse missing");

endmodule

bind cpu_phase_gen laser310_assertions u_phase_checks (
	.CLK50MHZ (CLK50MHZ),
	.RESET_N  (RESET_N),
	.turbo_i  (turbo_i),
	.cpu_clk_o(cpu_clk_o)
);

// ==== dv/laser310_tb.sv ====
`timescale 1ns/1ns

module laser310_tb;
	import laser_bus_pkg::*;
	import laser_kbd_pkg::*;

	typedef enum logic [2:0] {K_WRITE, K_READ, K_IOWR, K_VIDEO, K_CASS, K_TURBO} row_kind_e;

	typedef struct packed {
		row_kind_e   kind;
		logic [15:0] addr;
		logic [7:0]  data;       // Write data, or the level for cass and turbo rows
		kbd_event_t  key;        // Code 00 means no key event
		logic [7:0]  expected;
	} table_row_t;

	localparam kbd_event_t NO_KEY = '0;

	logic        CLK50MHZ;
	logic        RESET_N;
	cpu_bus_t    bus_i;
	logic        turbo_i;
	logic        key_strobe_i;
	logic        key_pressed_i;
	logic        key_extended_i;
	logic [7:0]  key_code_i;
	logic        cass_in_i;
	logic [10:0] vdg_addr_i;
	logic        cpu_clk_o;
	logic [7:0]  rd_data_o;
	io_outputs_t io_o;
	logic [7:0]  vdg_data_o;

	table_row_t  rows[$];
	int          table_len = 0;
	int          mismatch_count = 0;
	int          other_count = 0;
	logic [31:0] lcg_state;
	logic [31:0] rnd;
	logic [15:0] rand_addr [6];
	logic [7:0]  ram_model [2**RAM_AW];   // Expected main RAM contents

	tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clk (
		.clk_o  (CLK50MHZ),
		.rst_n_o(RESET_N)
	);

	laser310_top UUT (
		.CLK50MHZ      (CLK50MHZ),
		.RESET_N       (RESET_N),
		.bus_i         (bus_i),
		.turbo_i       (turbo_i),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.key_extended_i(key_extended_i),
		.key_code_i    (key_code_i),
		.cass_in_i     (cass_in_i),
		.vdg_addr_i    (vdg_addr_i),
		.cpu_clk_o     (cpu_clk_o),
		.rd_data_o     (rd_data_o),
		.io_o          (io_o),
		.vdg_data_o    (vdg_data_o)
	);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic kbd_event_t key_ev(input logic [7:0] code, input logic ext,
		input logic pressed);
		return kbd_event_t'{code, ext, pressed};
	endfunction

	task automatic add_row(input row_kind_e kind, input logic [15:0] addr,
		input logic [7:0] data, input kbd_event_t key, input logic [7:0] expected);
		rows.push_back(table_row_t'{kind, addr, data, key, expected});
	endtask

	task automatic check_value(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		assert (got === exp)
		else
		begin
			mismatch_count++;
			$display("mismatch at %0t ns: %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	// Returns on the falling edge inside the next CPU clock pulse
	task automatic wait_next_pulse(output int cycles);
		cycles = 0;
		do
		begin
			@(negedge CLK50MHZ);
			key_strobe_i = 1'b0;    // Key event lasts one clock
			cycles++;
		end
		while (cpu_clk_o !== 1'b1 && cycles < 32);
		if (cpu_clk_o !== 1'b1)
		begin
			other_count++;
			$display("no CPU clock pulse within %0d cycles at %0t ns", cycles, $time);
		end
	endtask

	task automatic apply_row(input table_row_t r);
		bus_i = '0;
		bus_i.addr = r.addr;
		case (r.kind)
			K_WRITE, K_IOWR:
			begin
				bus_i.wdata = r.data;
				bus_i.mreq  = 1'b1;
				bus_i.wr    = 1'b1;
			end
			K_READ, K_CASS:
			begin
				bus_i.mreq = 1'b1;
				bus_i.rd   = 1'b1;
			end
			K_VIDEO: vdg_addr_i = r.addr[10:0];
			K_TURBO: turbo_i = r.data[0];
			default: ;
		endcase
		if (r.kind == K_CASS)
			cass_in_i = r.data[0];
		if (r.key.code != 8'h00)
		begin
			key_code_i     = r.key.code;
			key_extended_i = r.key.extended;
			key_pressed_i  = r.key.pressed;
			key_strobe_i   = 1'b1;
		end
	endtask

	task automatic check_row(input table_row_t r, input int gap);
		case (r.kind)
			K_READ, K_CASS: check_value("rd_data_o", rd_data_o, r.expected);
			K_IOWR:         check_value("io_o", {3'b000, io_o}, r.expected);
			K_VIDEO:        check_value("vdg_data_o", vdg_data_o, r.expected);
			K_TURBO:        check_value("cpu_clk_o spacing", 8'(gap), r.expected);
			default: ;
		endcase
	endtask

	task automatic build_table();
		add_row(K_WRITE, 16'h7800, 8'hA5, NO_KEY, 8'h00);
		add_row(K_WRITE, 16'h8000, 8'h3C, NO_KEY, 8'h00);
		add_row(K_WRITE, 16'hB7FF, 8'h96, NO_KEY, 8'h00);
		add_row(K_READ,  16'h7800, 8'h00, NO_KEY, 8'hA5);
		add_row(K_READ,  16'h6000, 8'h00, NO_KEY, 8'hFF);   // Unmapped
		add_row(K_READ,  16'h8000, 8'h00, NO_KEY, 8'h3C);
		add_row(K_READ,  16'hB800, 8'h00, NO_KEY, 8'hFF);
		add_row(K_READ,  16'hB7FF, 8'h00, NO_KEY, 8'h96);
		add_row(K_WRITE, 16'h7005, 8'h5A, NO_KEY, 8'h00);
		add_row(K_VIDEO, 16'h0005, 8'h00, NO_KEY, 8'h5A);
		add_row(K_WRITE, 16'h77FF, 8'hC3, NO_KEY, 8'h00);
		add_row(K_VIDEO, 16'h07FF, 8'h00, NO_KEY, 8'hC3);
		add_row(K_READ,  16'h7005, 8'h00, NO_KEY, 8'h5A);
		add_row(K_IOWR,  16'h6800, 8'h20, NO_KEY, 8'h10);   // Speaker B is the MSB
		add_row(K_IOWR,  16'h6C00, 8'h1C, NO_KEY, 8'h07);   // css, ag, cass out
		add_row(K_IOWR,  16'h6800, 8'hC3, NO_KEY, 8'h08);   // Speaker A under unused bits
		add_row(K_READ,  16'h68FE, 8'h00, key_ev(8'h2C, 1'b0, 1'b1), 8'hFE);   // T
		add_row(K_READ,  16'h68EF, 8'h00, key_ev(8'h2C, 1'b0, 1'b0), 8'hFF);
		add_row(K_READ,  16'h68EF, 8'h00, key_ev(SC_UP, 1'b1, 1'b1), 8'hFD);
		add_row(K_READ,  16'h68FD, 8'h00, NO_KEY, 8'hFB);   // Ctrl
		add_row(K_READ,  16'h68FD, 8'h00, key_ev(SC_UP, 1'b1, 1'b0), 8'hFF);
		add_row(K_READ,  16'h68DF, 8'h00, key_ev(SC_ESC, 1'b0, 1'b1), 8'hFB);
		add_row(K_READ,  16'h68DF, 8'h00, key_ev(SC_ESC, 1'b0, 1'b0), 8'hFF);
		add_row(K_READ,  16'h68EF, 8'h00, key_ev(SC_LEFT, 1'b1, 1'b1), 8'hDF);
		add_row(K_READ,  16'h68EF, 8'h00, key_ev(SC_RIGHT, 1'b1, 1'b1), 8'hD7);
		add_row(K_READ,  16'h68EF, 8'h00, key_ev(SC_DOWN, 1'b1, 1'b1), 8'hC7);
		add_row(K_READ,  16'h68EE, 8'h00, key_ev(8'h2C, 1'b0, 1'b1), 8'hC6);   // Two rows
		add_row(K_READ,  16'h68FD, 8'h00, key_ev(SC_LEFT, 1'b1, 1'b0), 8'hFB);
		add_row(K_READ,  16'h68EE, 8'h00, key_ev(SC_RIGHT, 1'b1, 1'b0), 8'hEE);
		add_row(K_READ,  16'h68EE, 8'h00, key_ev(SC_DOWN, 1'b1, 1'b0), 8'hFE);
		add_row(K_READ,  16'h68EE, 8'h00, key_ev(8'h2C, 1'b0, 1'b0), 8'hFF);
		add_row(K_READ,  16'h68EF, 8'h00, key_ev(SC_BKSP, 1'b0, 1'b1), 8'hDF);
		add_row(K_READ,  16'h68EF, 8'h00, key_ev(SC_BKSP, 1'b0, 1'b0), 8'hFF);
		add_row(K_READ,  16'h68FB, 8'h00, key_ev(SC_RSHIFT, 1'b0, 1'b1), 8'hFB);
		add_row(K_READ,  16'h68FB, 8'h00, key_ev(SC_RSHIFT, 1'b0, 1'b0), 8'hFF);
		add_row(K_CASS,  16'h68FE, 8'h01, NO_KEY, 8'hBF);
		add_row(K_CASS,  16'h68FE, 8'h00, NO_KEY, 8'hFF);
		add_row(K_TURBO, 16'h0000, 8'h01, NO_KEY, 8'd4);
		add_row(K_WRITE, 16'h9000, 8'h77, NO_KEY, 8'h00);
		add_row(K_READ,  16'h9000, 8'h00, NO_KEY, 8'h77);
		add_row(K_TURBO, 16'h0000, 8'h00, NO_KEY, 8'd14);
		lcg_state = 32'd81175;
		for (int i = 0; i < 6; i++)
		begin
			rnd = next_random();
			rand_addr[i] = RAM_BASE + {2'b00, rnd[29:16]};
			rnd = next_random();
			ram_model[rand_addr[i][RAM_AW-1:0]] = rnd[27:20];
			add_row(K_WRITE, rand_addr[i], rnd[27:20], NO_KEY, 8'h00);
		end
		for (int i = 0; i < 6; i++)
			add_row(K_READ, rand_addr[i], 8'h00, NO_KEY, ram_model[rand_addr[i][RAM_AW-1:0]]);
	endtask

	task automatic print_error_counts();
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
	endtask

	initial
	begin
		int gap;
		bus_i          = '0;
		turbo_i        = 1'b0;
		key_strobe_i   = 1'b0;
		key_pressed_i  = 1'b0;
		key_extended_i = 1'b0;
		key_code_i     = 8'h00;
		cass_in_i      = 1'b0;
		vdg_addr_i     = '0;
		build_table();
		table_len = rows.size();
		wait (RESET_N === 1'b1);
		check_value("rd_data_o", rd_data_o, 8'hFF);
		check_value("io_o", {3'b000, io_o}, 8'h00);
		wait_next_pulse(gap);
		foreach (rows[i])
		begin
			apply_row(rows[i]);
			wait_next_pulse(gap);
			check_row(rows[i], gap);   // Sampled just before the next row starts
		end
		print_error_counts();
		if (mismatch_count == 0 && other_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Twice the normal CPU cycle per row plus reset
	initial
	begin
		wait (table_len != 0);
		#(table_len * 14 * 20 * 2 + 16 * 20);
		other_count++;
		$display("watchdog expired before the table finished");
		print_error_counts();
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
logic/laser_bus_pkg.sv
logic/laser_kbd_pkg.sv
logic/sync_ram.sv
logic/cpu_phase_gen.sv
logic/mem_map_decoder.sv
logic/keyboard_matrix.sv
logic/laser310_top.sv
dv/tb_clock_gen.sv
dv/laser310_assertions.sv
dv/laser310_tb.sv

// ==== Makefile ====
TOP = laser310_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir
